// File: source/rmw_cfg_pkg.sv
// default sizes of the counter bank; the rtl takes its real widths from module parameters
package rmw_cfg_pkg;

  // ---------------------------------------------------------------------
  // default widths
  // ---------------------------------------------------------------------

  // the bank holds two to the power of this many counters
  localparam int unsigned ADDR_W_DEF = 6;

  // counters wrap modulo two to this width
  localparam int unsigned DATA_W_DEF = 16;

  // the tag is opaque to the design and only returned with the response
  localparam int unsigned TAG_W_DEF = 4;

  // ---------------------------------------------------------------------
  // vectors at the default widths
  // ---------------------------------------------------------------------

  typedef logic [ADDR_W_DEF-1:0] addr_t;
  typedef logic [DATA_W_DEF-1:0] count_t;
  typedef logic [TAG_W_DEF-1:0]  tag_t;

endpackage

// File: source/rmw_cmd_pkg.sv
// opcode encoding and command word layout; bit 0 of the opcode must stay the write flag
package rmw_cmd_pkg;

  // ---------------------------------------------------------------------
  // opcodes
  // ---------------------------------------------------------------------

  localparam int unsigned OP_W = 2;

  typedef logic [OP_W-1:0] opcode_t;

  // every command returns the old value, only bit 0 decides whether it writes back
  localparam opcode_t OP_READ  = 2'b00;
  localparam opcode_t OP_ADD   = 2'b01;
  localparam opcode_t OP_CLEAR = 2'b11;

  // ---------------------------------------------------------------------
  // command word layout, low bits first
  // ---------------------------------------------------------------------

  // the opcode sits at the bottom so the pipe finds the write flag at bit 0
  localparam int unsigned CMD_OP_LSB   = 0;
  localparam int unsigned CMD_WR_BIT   = CMD_OP_LSB;
  localparam int unsigned CMD_OPND_LSB = CMD_OP_LSB + OP_W;

  // the tag follows the operand, so its position depends on the counter width
  function automatic int unsigned cmd_tag_lsb(input int unsigned data_w);
    return CMD_OPND_LSB + data_w;
  endfunction

  function automatic int unsigned cmd_width(input int unsigned data_w, input int unsigned tag_w);
    return OP_W + data_w + tag_w;
  endfunction

endpackage

// File: source/counter_ram.sv
// counter storage with no reset and no read-during-write bypass; the read returns old data
`timescale 1ns/1ps

module counter_ram #(
  parameter int unsigned ADDR_WIDTH = rmw_cfg_pkg::ADDR_W_DEF,
  parameter int unsigned DATA_WIDTH = rmw_cfg_pkg::DATA_W_DEF
) (
  input  logic                  clk,
  input  logic                  rd_valid,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data,
  input  logic                  wr_valid,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data
);

  localparam int unsigned DEPTH = 1 << ADDR_WIDTH;

  typedef logic [DATA_WIDTH-1:0] word_t;

  // one entry per counter address
  word_t mem [DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, the output holds while rd_valid is low
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: source/counter_update.sv
// new counter value from the opcode; purely combinational and only meaningful for writing ops
`timescale 1ns/1ps

module counter_update #(
  parameter int unsigned DATA_WIDTH = rmw_cfg_pkg::DATA_W_DEF
) (
  input  rmw_cmd_pkg::opcode_t  op,
  input  logic [DATA_WIDTH-1:0] old_value,
  input  logic [DATA_WIDTH-1:0] operand,
  output logic [DATA_WIDTH-1:0] new_value
);
  import rmw_cmd_pkg::*;

  typedef logic [DATA_WIDTH-1:0] word_t;

  word_t sum;

  // the sum is truncated to the counter width, so the counter wraps
  assign sum = old_value + operand;

  // ---------------------------------------------------------------------
  // opcode decode
  // ---------------------------------------------------------------------

  always_comb begin
    case (op)
      OP_ADD: begin
        new_value = sum;
      end
      OP_CLEAR: begin
        new_value = '0;
      end
      OP_READ: begin
        // a read never writes, so the value only has to be well defined
        new_value = old_value;
      end
      default: begin
        // the spare encoding leaves the counter as it is
        new_value = old_value;
      end
    endcase
  end

endmodule

// File: source/rmw_mem_pipe.sv
// four-stage rmw pipe that never stalls; needs a ram with a one-cycle registered read
`timescale 1ns/1ps

module rmw_mem_pipe #(
  parameter int unsigned CMD_WIDTH  = rmw_cmd_pkg::OP_W,
  parameter int unsigned ADDR_WIDTH = rmw_cfg_pkg::ADDR_W_DEF,
  parameter int unsigned DATA_WIDTH = rmw_cfg_pkg::DATA_W_DEF
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  input  logic [CMD_WIDTH-1:0]  cmd,
  input  logic [ADDR_WIDTH-1:0] addr,
  output logic                  p0_mem_rd_valid,
  output logic [ADDR_WIDTH-1:0] p0_mem_rd_addr,
  input  logic [DATA_WIDTH-1:0] p1_mem_rd_data,
  output logic                  p2_cmd_valid,
  output logic [CMD_WIDTH-1:0]  p2_cmd,
  output logic [DATA_WIDTH-1:0] p2_mem_rd_data,
  input  logic [DATA_WIDTH-1:0] p2_write_data,
  output logic                  p3_mem_wr_valid,
  output logic [ADDR_WIDTH-1:0] p3_mem_wr_addr,
  output logic [DATA_WIDTH-1:0] p3_mem_wr_data
);
  import rmw_cmd_pkg::*;

  typedef logic [CMD_WIDTH-1:0]  cmd_word_t;
  typedef logic [ADDR_WIDTH-1:0] word_addr_t;
  typedef logic [DATA_WIDTH-1:0] word_t;

  logic       cmd_wr;
  logic       p0_wr;
  logic       p1_valid;
  logic       p1_wr;
  logic       p2_wr;
  cmd_word_t  p0_cmd;
  cmd_word_t  p1_cmd;
  word_addr_t p1_addr;
  word_addr_t p2_addr;
  word_t      p1_old_value;

  // forwarding selects, each set while the command is in p0 and used in p1
  logic       fwd_p2_sel;
  logic       fwd_p3_sel;
  logic       fwd_ret_sel;
  word_t      fwd_ret_data;

  // every command reads, and only those with the write flag set go on to write
  assign cmd_wr = cmd_valid && cmd[CMD_WR_BIT];

  // ---------------------------------------------------------------------
  // stage valids and address compares
  // ---------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p0_mem_rd_valid <= 1'b0;
      p0_wr           <= 1'b0;
      p1_valid        <= 1'b0;
      p1_wr           <= 1'b0;
      p2_cmd_valid    <= 1'b0;
      p2_wr           <= 1'b0;
      p3_mem_wr_valid <= 1'b0;
      fwd_p2_sel      <= 1'b0;
      fwd_p3_sel      <= 1'b0;
      fwd_ret_sel     <= 1'b0;
    end else begin
      p0_mem_rd_valid <= cmd_valid;
      p0_wr           <= cmd_wr;
      p1_valid        <= p0_mem_rd_valid;
      p1_wr           <= p0_wr;
      p2_cmd_valid    <= p1_valid;
      p2_wr           <= p1_wr;
      p3_mem_wr_valid <= p2_wr;
      // the write now in p1 will be producing its data in p2 when this command enters p2
      fwd_p2_sel      <= p1_wr && (p1_addr == p0_mem_rd_addr);
      // the write now in p2 will sit in p3 at that point
      fwd_p3_sel      <= p2_wr && (p2_addr == p0_mem_rd_addr);
      // a write retiring on the same edge as this read is missed by the ram
      fwd_ret_sel     <= p3_mem_wr_valid && (p3_mem_wr_addr == p0_mem_rd_addr);
    end
  end

  // ---------------------------------------------------------------------
  // old value select on entry to p2
  // ---------------------------------------------------------------------

  // the youngest older write to the same counter wins over the rest
  always_comb begin
    if (fwd_p2_sel) begin
      p1_old_value = p2_write_data;
    end else if (fwd_p3_sel) begin
      p1_old_value = p3_mem_wr_data;
    end else if (fwd_ret_sel) begin
      p1_old_value = fwd_ret_data;
    end else begin
      p1_old_value = p1_mem_rd_data;
    end
  end

  // ---------------------------------------------------------------------
  // payload registers, loaded only when their stage takes a command
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      p0_cmd         <= cmd;
      p0_mem_rd_addr <= addr;
    end
    if (p0_mem_rd_valid) begin
      p1_cmd       <= p0_cmd;
      p1_addr      <= p0_mem_rd_addr;
      // keep the retiring write data, it is gone from p3 by the next cycle
      fwd_ret_data <= p3_mem_wr_data;
    end
    if (p1_valid) begin
      p2_cmd         <= p1_cmd;
      p2_addr        <= p1_addr;
      p2_mem_rd_data <= p1_old_value;
    end
    if (p2_wr) begin
      p3_mem_wr_addr <= p2_addr;
      p3_mem_wr_data <= p2_write_data;
    end
  end

endmodule

// File: source/counter_rmw_top.sv
// counter bank top; takes one command every cycle with cmd_valid high and has no back-pressure
`timescale 1ns/1ps

module counter_rmw_top #(
  parameter int unsigned ADDR_WIDTH = rmw_cfg_pkg::ADDR_W_DEF,
  parameter int unsigned DATA_WIDTH = rmw_cfg_pkg::DATA_W_DEF,
  parameter int unsigned TAG_WIDTH  = rmw_cfg_pkg::TAG_W_DEF
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  input  rmw_cmd_pkg::opcode_t  cmd_op,
  input  logic [ADDR_WIDTH-1:0] cmd_addr,
  input  logic [DATA_WIDTH-1:0] cmd_operand,
  input  logic [TAG_WIDTH-1:0]  cmd_tag,
  output logic                  rsp_valid,
  output logic [DATA_WIDTH-1:0] rsp_data,
  output logic [TAG_WIDTH-1:0]  rsp_tag
);
  import rmw_cmd_pkg::*;

  localparam int unsigned CMD_WIDTH = cmd_width(DATA_WIDTH, TAG_WIDTH);
  localparam int unsigned TAG_LSB   = cmd_tag_lsb(DATA_WIDTH);

  logic [CMD_WIDTH-1:0]  cmd_word;
  logic                  p0_mem_rd_valid;
  logic [ADDR_WIDTH-1:0] p0_mem_rd_addr;
  logic [DATA_WIDTH-1:0] p1_mem_rd_data;
  logic                  p2_cmd_valid;
  logic [CMD_WIDTH-1:0]  p2_cmd;
  logic [DATA_WIDTH-1:0] p2_mem_rd_data;
  logic [DATA_WIDTH-1:0] p2_write_data;
  opcode_t               p2_op;
  logic [DATA_WIDTH-1:0] p2_operand;
  logic                  p3_mem_wr_valid;
  logic [ADDR_WIDTH-1:0] p3_mem_wr_addr;
  logic [DATA_WIDTH-1:0] p3_mem_wr_data;

  // ---------------------------------------------------------------------
  // command word packing
  // ---------------------------------------------------------------------

  // tag on top, operand in the middle, opcode at the bottom
  assign cmd_word   = {cmd_tag, cmd_operand, cmd_op};
  assign p2_op      = p2_cmd[CMD_OP_LSB +: OP_W];
  assign p2_operand = p2_cmd[CMD_OPND_LSB +: DATA_WIDTH];

  // the response leaves from p2 with the forwarded old value
  assign rsp_valid = p2_cmd_valid;
  assign rsp_data  = p2_mem_rd_data;
  assign rsp_tag   = p2_cmd[TAG_LSB +: TAG_WIDTH];

  // ---------------------------------------------------------------------
  // pipe, storage and update
  // ---------------------------------------------------------------------

  rmw_mem_pipe #(
    .CMD_WIDTH  (CMD_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_pipe (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_valid       (cmd_valid),
    .cmd             (cmd_word),
    .addr            (cmd_addr),
    .p0_mem_rd_valid (p0_mem_rd_valid),
    .p0_mem_rd_addr  (p0_mem_rd_addr),
    .p1_mem_rd_data  (p1_mem_rd_data),
    .p2_cmd_valid    (p2_cmd_valid),
    .p2_cmd          (p2_cmd),
    .p2_mem_rd_data  (p2_mem_rd_data),
    .p2_write_data   (p2_write_data),
    .p3_mem_wr_valid (p3_mem_wr_valid),
    .p3_mem_wr_addr  (p3_mem_wr_addr),
    .p3_mem_wr_data  (p3_mem_wr_data)
  );

  counter_ram #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_ram (
    .clk      (clk),
    .rd_valid (p0_mem_rd_valid),
    .rd_addr  (p0_mem_rd_addr),
    .rd_data  (p1_mem_rd_data),
    .wr_valid (p3_mem_wr_valid),
    .wr_addr  (p3_mem_wr_addr),
    .wr_data  (p3_mem_wr_data)
  );

  counter_update #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_update (
    .op        (p2_op),
    .old_value (p2_mem_rd_data),
    .operand   (p2_operand),
    .new_value (p2_write_data)
  );

endmodule

// File: dv/counter_rmw_tb.sv
// self-checking testbench at the default widths; ram data is unknown until a counter is cleared
`timescale 1ns/1ps

module counter_rmw_tb;
  import rmw_cfg_pkg::*;
  import rmw_cmd_pkg::*;

  localparam int DEPTH        = 1 << ADDR_W_DEF;
  localparam int RESET_CYCLES = 16;
  localparam int N_GAP        = 10;
  localparam int N_B2B        = 8;
  localparam int N_FWD        = 4;
  localparam int N_RAND       = 300;
  localparam int N_ISO        = 6;
  localparam int MAX_IDLE     = 5;
  localparam int N_CMDS = 2 * DEPTH + N_GAP + N_B2B + 5 * N_FWD + N_RAND + N_ISO;
  // no command is followed by more than MAX_IDLE idle cycles, plus a margin for the drain
  localparam int TIMEOUT = RESET_CYCLES + N_CMDS * (1 + MAX_IDLE) + 20;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    cmd_valid;
  opcode_t cmd_op;
  addr_t   cmd_addr;
  count_t  cmd_operand;
  tag_t    cmd_tag;
  logic    rsp_valid;
  count_t  rsp_data;
  tag_t    rsp_tag;

  // reference counters and whether each one has been cleared yet
  count_t model_cnt [DEPTH];
  bit     model_known [DEPTH];

  // expected responses in command order
  count_t exp_data_q [$];
  tag_t   exp_tag_q [$];
  bit     exp_chk_q [$];
  int     exp_due_q [$];

  int     cycle = 0;
  int     errors = 0;
  int     cmd_count = 0;
  int     rsp_count = 0;
  integer seed;

  always #5 clk = ~clk;

  counter_rmw_top #(
    .ADDR_WIDTH (ADDR_W_DEF),
    .DATA_WIDTH (DATA_W_DEF),
    .TAG_WIDTH  (TAG_W_DEF)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd_op      (cmd_op),
    .cmd_addr    (cmd_addr),
    .cmd_operand (cmd_operand),
    .cmd_tag     (cmd_tag),
    .rsp_valid   (rsp_valid),
    .rsp_data    (rsp_data),
    .rsp_tag     (rsp_tag)
  );

  // ----------------------------------------------------------------------
  // reference model and drivers
  // ----------------------------------------------------------------------

  // returns the old value, then applies add or clear to the model counter
  function automatic count_t model_apply(input opcode_t op, input addr_t addr,
                                         input count_t operand);
    count_t old;
    old = model_cnt[addr];
    if (op == OP_ADD) begin
      model_cnt[addr] = old + operand;
    end else if (op == OP_CLEAR) begin
      model_cnt[addr]   = '0;
      model_known[addr] = 1'b1;
    end
    return old;
  endfunction

  task automatic send_cmd(input opcode_t op, input addr_t addr, input count_t operand,
                          input tag_t tag);
    @(posedge clk);
    cmd_valid   <= 1'b1;
    cmd_op      <= op;
    cmd_addr    <= addr;
    cmd_operand <= operand;
    cmd_tag     <= tag;
    exp_chk_q.push_back(model_known[addr]);
    exp_data_q.push_back(model_apply(op, addr, operand));
    exp_tag_q.push_back(tag);
    // the dut samples on the next edge, the response is seen three edges after that
    exp_due_q.push_back(cycle + 4);
    cmd_count++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      cmd_valid <= 1'b0;
    end
  endtask

  // ----------------------------------------------------------------------
  // cycle limit and response checker
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  always @(posedge clk) begin : compare_rsp
    count_t exp_data;
    tag_t   exp_tag;
    bit     exp_chk;
    int     exp_due;
    if (!rst_n) begin
      // the reset has reached every flop by the end of the first cycle
      if (cycle > 0) begin
        assert (rsp_valid === 1'b0) else begin
          errors++;
          $display("[ERROR] %0t rsp_valid expected 0 actual %b", $time, rsp_valid);
        end
      end
    end else if (rsp_valid === 1'b1) begin
      rsp_count++;
      if (exp_data_q.size() == 0) begin
        errors++;
        $display("%0t a response with tag %h came with no command outstanding", $time, rsp_tag);
      end else begin
        exp_data = exp_data_q.pop_front();
        exp_tag  = exp_tag_q.pop_front();
        exp_chk  = exp_chk_q.pop_front();
        exp_due  = exp_due_q.pop_front();
        assert (rsp_tag === exp_tag) else begin
          errors++;
          $display("[ERROR] %0t rsp_tag expected %h actual %h", $time, exp_tag, rsp_tag);
        end
        // old values of counters never cleared are unknown in the ram
        if (exp_chk) begin
          assert (rsp_data === exp_data) else begin
            errors++;
            $display("[ERROR] %0t rsp_data expected %h actual %h", $time, exp_data, rsp_data);
          end
        end
        assert (cycle == exp_due) else begin
          errors++;
          $display("[ERROR] %0t rsp_valid cycle expected %0d actual %0d", $time, exp_due, cycle);
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  initial begin
    logic [31:0] r;
    opcode_t     op;
    seed        = 25430;
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd_op      = OP_READ;
    cmd_addr    = '0;
    cmd_operand = '0;
    cmd_tag     = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // clear every counter, then read them all back as zero
    for (int a = 0; a < DEPTH; a++) send_cmd(OP_CLEAR, addr_t'(a), '0, tag_t'(a));
    for (int a = 0; a < DEPTH; a++) send_cmd(OP_READ, addr_t'(a), '0, tag_t'(a + 3));

    // spaced adds go through the ram and wrap past the top after five steps
    for (int i = 0; i < N_GAP; i++) begin
      send_cmd(OP_ADD, addr_t'(5), 16'h3000, tag_t'(i));
      idle_cycles(3);
    end

    // adds on consecutive cycles take the old value from the write in p2
    for (int i = 0; i < N_B2B; i++) send_cmd(OP_ADD, addr_t'(9), count_t'(16'h0101 * (i + 1)),
                                            tag_t'(i));
    idle_cycles(4);

    // one unrelated command in between moves the first write into p3
    for (int k = 0; k < N_FWD; k++) begin
      send_cmd(OP_ADD, addr_t'(12 + k), 16'd7, tag_t'(k));
      send_cmd(OP_ADD, addr_t'(40 + k), 16'd1, tag_t'(k + 1));
      send_cmd(OP_ADD, addr_t'(12 + k), 16'd3, tag_t'(k + 2));
      send_cmd(OP_CLEAR, addr_t'(12 + k), '0, tag_t'(k + 3));
      send_cmd(OP_READ, addr_t'(12 + k), '0, tag_t'(k + 4));
      idle_cycles(3);
    end

    // a random mix over four counters makes adds twice as likely as reads or clears
    for (int i = 0; i < N_RAND; i++) begin
      r  = $random(seed);
      op = (r[1:0] == 2'b11) ? OP_CLEAR : ((r[1:0] == 2'b00) ? OP_READ : OP_ADD);
      send_cmd(op, addr_t'(r[3:2]), count_t'(r[31:16]), tag_t'(r[7:4]));
      idle_cycles((r[10:8] > 4) ? r[10:8] - 4 : 0);
    end

    // the checker holds each of these isolated reads to its response cycle
    for (int i = 0; i < N_ISO; i++) begin
      send_cmd(OP_READ, addr_t'(i), '0, tag_t'(i));
      idle_cycles(MAX_IDLE);
    end
    idle_cycles(8);

    assert (exp_data_q.size() == 0) else begin
      errors++;
      $display("%0d expected responses never arrived", exp_data_q.size());
    end
    assert (rsp_count == cmd_count) else begin
      errors++;
      $display("responses and commands differ: %0d against %0d", rsp_count, cmd_count);
    end
    $display("errors: %0d  commands: %0d  responses: %0d", errors, cmd_count, rsp_count);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: verilog.f
source/rmw_cfg_pkg.sv
source/rmw_cmd_pkg.sv
source/counter_ram.sv
source/counter_update.sv
source/rmw_mem_pipe.sv
source/counter_rmw_top.sv
dv/counter_rmw_tb.sv

// File: Bender.yml
package:
  name: counter_rmw

sources:
  # packages first, the rtl modules import from them
  - source/rmw_cfg_pkg.sv
  - source/rmw_cmd_pkg.sv
  - source/counter_ram.sv
  - source/counter_update.sv
  - source/rmw_mem_pipe.sv
  - source/counter_rmw_top.sv
  - target: test
    files:
      - dv/counter_rmw_tb.sv
